/* pcxt_pkg.sv */
////////////////////////////////////////
// pcxt glue package
// widths, download indexes, rom windows, loader timing,
// cpu speed codes and the bios address union
////////////////////////////////////////

`default_nettype none

package pcxt_pkg;

	// bus and data widths
	localparam int IOCTL_ADDR_W = 25;
	localparam int BUS_ADDR_W   = 20;
	localparam int BYTE_W       = 8;
	localparam int SAMPLE_W     = 16;
	localparam int MIX_W        = 17;
	localparam int TANDY_W      = 8;

	// download index per rom image
	localparam int BIOS_IDX_PCXT  = 1;
	localparam int BIOS_IDX_TANDY = 2;
	localparam int BIOS_IDX_XTIDE = 3;

	// rom placement in the 1M map
	localparam logic [3:0] ROM_SEGMENT = 4'hF;
	// EC000 window for the xt-ide option rom
	localparam logic [5:0] XTIDE_BANK  = 6'b111011;

	// memory write slot, in chipset cycles
	localparam int BIOS_WRITE_PULSE = 20;
	localparam int BIOS_WRITE_CYCLE = 40;

	// loader states
	localparam logic [1:0] LOAD_IDLE    = 2'd0;
	localparam logic [1:0] LOAD_WAIT    = 2'd1;
	localparam logic [1:0] LOAD_WRITE   = 2'd2;
	localparam logic [1:0] LOAD_RECOVER = 2'd3;

	// cpu reset stretch after system reset
	localparam int CPU_RESET_HOLD = 42;

	// cpu speed request codes
	localparam logic [1:0] SPEED_4_77   = 2'd0;
	localparam logic [1:0] SPEED_7_16   = 2'd1;
	localparam logic [1:0] SPEED_14_318 = 2'd2;

	// strobe lanes
	localparam int UART_SPEED_W = 2;
	localparam int NUM_STROBES  = 2;
	localparam int STROBE_OPL2  = 0;
	localparam int STROBE_UART  = 1;

	// one 20 bit bus address, decoded as the 64K system rom
	// or as the 16K xt-ide window
	typedef union packed {
		struct packed {
			logic [BUS_ADDR_W-17:0] segment;
			logic [15:0]            offset;
		} rom64k;
		struct packed {
			logic [BUS_ADDR_W-15:0] bank;
			logic [13:0]            offset;
		} xtide;
	} bios_addr_t;

endpackage

`default_nettype wire

/* clock_strobes.sv */
////////////////////////////////////////
// clock strobes
// slow opl2 and uart clocks become one cycle enables,
// uart enable picked by the uart speed setting
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clock_strobes (
	input  wire                              clk_chipset,
	input  wire                              reset,
	input  wire                              opl2_clk_i,
	input  wire                              uart_clk_i,
	input  wire                              uart_slow_clk_i,
	input  wire [pcxt_pkg::UART_SPEED_W-1:0] uart_speed_i,
	output logic                             opl2_en_o,
	output logic                             uart_clk_en_o
);

	import pcxt_pkg::*;

	// raw slow clocks, one per lane
	logic [NUM_STROBES-1:0] clk_in;
	logic [NUM_STROBES-1:0] strobe;

	assign clk_in[STROBE_OPL2] = opl2_clk_i;
	assign clk_in[STROBE_UART] = uart_clk_i;

	for (genvar lane = 0; lane < NUM_STROBES; lane++) begin : g_lane
		// two flops to settle, third one for the edge
		logic [2:0] sync;

		always_ff @(posedge clk_chipset or posedge reset) begin
			if (reset) begin
				sync         <= 3'b000;
				strobe[lane] <= 1'b0;
			end else begin
				sync         <= {sync[1:0], clk_in[lane]};
				// rising edge seen between stage 1 and stage 2
				strobe[lane] <= sync[1] & ~sync[2];
			end
		end
	end

	assign opl2_en_o = strobe[STROBE_OPL2];

	// setting 0 runs the uart from the slow clock level directly
	assign uart_clk_en_o = (uart_speed_i == '0) ? uart_slow_clk_i : strobe[STROBE_UART];

endmodule

`default_nettype wire

/* cpu_clock_select.sv */
////////////////////////////////////////
// cpu clock select
// speed request taken only when the bus unit is done,
// chosen clock level resynchronized to clk_chipset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_clock_select (
	input  wire       clk_chipset,
	input  wire       reset,
	input  wire       clk_4_77_i,
	input  wire       clk_7_16_i,
	input  wire       clk_14_318_i,
	input  wire [1:0] speed_sel_i,
	input  wire       biu_done_i,
	output logic      clk_cpu_o,
	output logic      turbo_mode_o
);

	import pcxt_pkg::*;

	logic [1:0] speed_q;
	logic       clk_sel;
	logic [1:0] clk_sync;

	// speed latch
	// only between bus cycles, so the cpu never sees a short phase
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			speed_q      <= SPEED_4_77;
			turbo_mode_o <= 1'b0;
		end else if (biu_done_i) begin
			speed_q      <= speed_sel_i;
			turbo_mode_o <= (speed_sel_i == SPEED_7_16) || (speed_sel_i == SPEED_14_318);
		end
	end

	// clock level mux, unknown codes fall back to 4.77
	always_comb begin
		case (speed_q)
			SPEED_14_318: clk_sel = clk_14_318_i;
			SPEED_7_16:   clk_sel = clk_7_16_i;
			default:      clk_sel = clk_4_77_i;
		endcase
	end

	// three flop resync of the selected level
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			clk_sync  <= 2'b00;
			clk_cpu_o <= 1'b0;
		end else begin
			clk_sync  <= {clk_sync[0], clk_sel};
			clk_cpu_o <= clk_sync[1];
		end
	end

endmodule

`default_nettype wire

/* cpu_reset_seq.sv */
////////////////////////////////////////
// cpu reset sequencer
// stretches cpu reset past system reset,
// samples the machine model while in reset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_reset_seq (
	input  wire  clk_chipset,
	input  wire  reset,
	input  wire  model_tandy_i,
	output logic reset_cpu_o,
	output logic tandy_mode_o
);

	import pcxt_pkg::*;

	// counts edges since reset release
	logic [$clog2(CPU_RESET_HOLD)-1:0] hold_cnt;

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			reset_cpu_o <= 1'b1;
			hold_cnt    <= '0;
		end else if (reset_cpu_o) begin
			// release on the CPU_RESET_HOLD-th edge, then stay put
			if (hold_cnt == ($bits(hold_cnt))'(CPU_RESET_HOLD - 1)) begin
				reset_cpu_o <= 1'b0;
			end else begin
				hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	// model select
	// follows the input during reset, frozen once reset drops
	always_ff @(posedge clk_chipset) begin
		if (reset) begin
			tandy_mode_o <= model_tandy_i;
		end
	end

endmodule

`default_nettype wire

/* bios_loader.sv */
////////////////////////////////////////
// bios loader
// download bytes to timed memory writes for the pcxt,
// tandy and xt-ide roms, plus protect and request flags
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bios_loader (
	input  wire                              clk_chipset,
	input  wire                              reset,
	input  wire                              sdram_ready_i,
	input  wire                              ioctl_download_i,
	input  wire                              ioctl_wr_i,
	input  wire [pcxt_pkg::BYTE_W-1:0]       ioctl_index_i,
	input  wire [pcxt_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  wire [pcxt_pkg::BYTE_W-1:0]       ioctl_data_i,
	input  wire                              processor_ready_i,
	input  wire                              address_direction_i,
	input  wire                              tandy_mode_i,
	output logic                             bios_request_o,
	output logic                             bios_protect_o,
	output pcxt_pkg::bios_addr_t             bios_address_o,
	output logic [pcxt_pkg::BYTE_W-1:0]      bios_data_o,
	output logic                             bios_write_n_o,
	output logic                             tandy_bios_flag_o
);

	import pcxt_pkg::*;

	logic [1:0]                          state;
	logic [$clog2(BIOS_WRITE_CYCLE+1)-1:0] slot_cnt;
	logic                                tandy_write;
	logic                                low_64k;
	logic                                sel_pcxt;
	logic                                sel_tandy;
	logic                                sel_xtide;
	logic                                byte_ok;
	bios_addr_t                          next_addr;

	////////////////////////////////////////
	// target decode
	////////////////////////////////////////

	// system roms only fit in the first 64K of the image
	assign low_64k   = (ioctl_addr_i[IOCTL_ADDR_W-1:16] == '0);
	assign sel_pcxt  = (ioctl_index_i == BYTE_W'(BIOS_IDX_PCXT)) && low_64k;
	assign sel_tandy = (ioctl_index_i == BYTE_W'(BIOS_IDX_TANDY)) && low_64k;
	assign sel_xtide = (ioctl_index_i == BYTE_W'(BIOS_IDX_XTIDE));
	assign byte_ok   = sel_pcxt | sel_tandy | sel_xtide;

	always_comb begin
		next_addr = '1;
		if (sel_pcxt || sel_tandy) begin
			// F0000 to FFFFF
			next_addr.rom64k.segment = ROM_SEGMENT;
			next_addr.rom64k.offset  = ioctl_addr_i[15:0];
		end else if (sel_xtide) begin
			// EC000 to EFFFF
			next_addr.xtide.bank   = XTIDE_BANK;
			next_addr.xtide.offset = ioctl_addr_i[13:0];
		end
	end

	////////////////////////////////////////
	// write sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			state          <= LOAD_IDLE;
			slot_cnt       <= '0;
			bios_protect_o <= 1'b1;
			bios_request_o <= 1'b0;
			bios_address_o <= '1;
			bios_data_o    <= '1;
			bios_write_n_o <= 1'b1;
			tandy_write    <= 1'b0;
		end else if (!sdram_ready_i) begin
			// memory not up yet, keep everything parked
			state          <= LOAD_IDLE;
			slot_cnt       <= '0;
			bios_protect_o <= 1'b1;
			bios_request_o <= 1'b0;
			bios_address_o <= '1;
			bios_data_o    <= '1;
			bios_write_n_o <= 1'b1;
			tandy_write    <= 1'b0;
		end else begin
			case (state)
				LOAD_IDLE: begin
					bios_protect_o <= 1'b1;
					bios_request_o <= ioctl_download_i;
					bios_address_o <= '1;
					bios_data_o    <= '1;
					bios_write_n_o <= 1'b1;
					slot_cnt       <= '0;
					tandy_write    <= 1'b0;
					// wait for the cpu to let go of the bus
					if (ioctl_download_i && !processor_ready_i && address_direction_i) begin
						state <= LOAD_WAIT;
					end
				end
				LOAD_WAIT: begin
					bios_protect_o <= 1'b0;
					bios_request_o <= 1'b1;
					slot_cnt       <= '0;
					if (!ioctl_download_i) begin
						state       <= LOAD_IDLE;
						tandy_write <= 1'b0;
					end else if (ioctl_wr_i && byte_ok) begin
						bios_address_o <= next_addr;
						bios_data_o    <= ioctl_data_i;
						tandy_write    <= sel_tandy;
						state          <= LOAD_WRITE;
					end
				end
				LOAD_WRITE: begin
					bios_protect_o <= 1'b0;
					bios_request_o <= 1'b1;
					slot_cnt       <= slot_cnt + 1'b1;
					// low for BIOS_WRITE_PULSE edges
					if (slot_cnt == ($bits(slot_cnt))'(BIOS_WRITE_PULSE)) begin
						bios_write_n_o <= 1'b1;
						state          <= LOAD_RECOVER;
					end else begin
						bios_write_n_o <= 1'b0;
					end
				end
				default: begin
					// recover, rest of the byte slot with the bus idle
					bios_protect_o <= 1'b0;
					bios_request_o <= 1'b1;
					bios_address_o <= '1;
					bios_data_o    <= '1;
					bios_write_n_o <= 1'b1;
					tandy_write    <= 1'b0;
					slot_cnt       <= slot_cnt + 1'b1;
					if (slot_cnt == ($bits(slot_cnt))'(BIOS_WRITE_CYCLE)) begin
						state <= LOAD_WAIT;
					end
				end
			endcase
		end
	end

	// chipset sees the image type only during the strobe
	assign tandy_bios_flag_o = bios_write_n_o ? tandy_mode_i : tandy_write;

endmodule

`default_nettype wire

/* audio_dac.sv */
////////////////////////////////////////
// audio dac
// opl2, speaker and tandy mixer,
// first order sigma-delta bitstream
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_dac (
	input  wire                                 clk_chipset,
	input  wire                                 reset,
	input  wire signed [pcxt_pkg::SAMPLE_W-1:0] opl_sample_i,
	input  wire                                 speaker_i,
	input  wire        [pcxt_pkg::TANDY_W-1:0]  tandy_sample_i,
	output logic       [pcxt_pkg::SAMPLE_W-1:0] dac_sample_o,
	output logic                                audio_o
);

	import pcxt_pkg::*;

	logic             spk_n;
	logic [MIX_W-1:0] mix;
	// 15 bit accumulator, carry is the output bit
	logic [MIX_W-3:0] acc;
	logic [MIX_W-2:0] acc_sum;

	// speaker is active low into the mix, weight 2^14
	assign spk_n = ~speaker_i;

	// modulo 2^17 sum
	// tandy weight 2^9
	assign mix = {opl_sample_i[SAMPLE_W-1], opl_sample_i}
		+ {{(MIX_W-15){1'b0}}, spk_n, 14'b0}
		+ {tandy_sample_i, {(MIX_W-TANDY_W){1'b0}}};

	assign acc_sum = {1'b0, acc} + {1'b0, mix[MIX_W-1:2]};

	// word out for a parallel dac
	always_ff @(posedge clk_chipset) begin
		dac_sample_o <= mix[MIX_W-1:1];
	end

	// sigma-delta loop
	always_ff @(posedge clk_chipset or posedge reset) begin
		if (reset) begin
			acc     <= '0;
			audio_o <= 1'b0;
		end else begin
			acc     <= acc_sum[MIX_W-3:0];
			audio_o <= acc_sum[MIX_W-2];
		end
	end

endmodule

`default_nettype wire

/* pcxt_glue_top.sv */
////////////////////////////////////////
// pcxt chipset glue, top level
// strobes, cpu clock and reset, bios loader, audio
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pcxt_glue_top (
	input  wire                                 clk_chipset,
	input  wire                                 reset,
	// download
	input  wire                                 sdram_ready_i,
	input  wire                                 ioctl_download_i,
	input  wire                                 ioctl_wr_i,
	input  wire        [pcxt_pkg::BYTE_W-1:0]       ioctl_index_i,
	input  wire        [pcxt_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
	input  wire        [pcxt_pkg::BYTE_W-1:0]       ioctl_data_i,
	input  wire                                 processor_ready_i,
	input  wire                                 address_direction_i,
	input  wire                                 model_tandy_i,
	// cpu clocking
	input  wire                                 clk_4_77_i,
	input  wire                                 clk_7_16_i,
	input  wire                                 clk_14_318_i,
	input  wire        [1:0]                    speed_sel_i,
	input  wire                                 biu_done_i,
	// slow clocks
	input  wire                                 opl2_clk_i,
	input  wire                                 uart_clk_i,
	input  wire                                 uart_slow_clk_i,
	input  wire        [pcxt_pkg::UART_SPEED_W-1:0] uart_speed_i,
	// sound sources
	input  wire signed [pcxt_pkg::SAMPLE_W-1:0] opl_sample_i,
	input  wire                                 speaker_i,
	input  wire        [pcxt_pkg::TANDY_W-1:0]  tandy_sample_i,
	// outputs
	output logic                                reset_cpu_o,
	output logic                                bios_request_o,
	output logic                                bios_protect_o,
	output pcxt_pkg::bios_addr_t                bios_address_o,
	output logic       [pcxt_pkg::BYTE_W-1:0]   bios_data_o,
	output logic                                bios_write_n_o,
	output logic                                tandy_bios_flag_o,
	output logic                                clk_cpu_o,
	output logic                                turbo_mode_o,
	output logic                                opl2_en_o,
	output logic                                uart_clk_en_o,
	output logic       [pcxt_pkg::SAMPLE_W-1:0] dac_sample_o,
	output logic                                audio_o
);

	// model latched at reset, used by the loader flag
	logic tandy_mode;

	clock_strobes u_clock_strobes (
		.clk_chipset     (clk_chipset),
		.reset           (reset),
		.opl2_clk_i      (opl2_clk_i),
		.uart_clk_i      (uart_clk_i),
		.uart_slow_clk_i (uart_slow_clk_i),
		.uart_speed_i    (uart_speed_i),
		.opl2_en_o       (opl2_en_o),
		.uart_clk_en_o   (uart_clk_en_o)
	);

	cpu_clock_select u_cpu_clock_select (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.clk_4_77_i   (clk_4_77_i),
		.clk_7_16_i   (clk_7_16_i),
		.clk_14_318_i (clk_14_318_i),
		.speed_sel_i  (speed_sel_i),
		.biu_done_i   (biu_done_i),
		.clk_cpu_o    (clk_cpu_o),
		.turbo_mode_o (turbo_mode_o)
	);

	cpu_reset_seq u_cpu_reset_seq (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.model_tandy_i (model_tandy_i),
		.reset_cpu_o   (reset_cpu_o),
		.tandy_mode_o  (tandy_mode)
	);

	bios_loader u_bios_loader (
		.clk_chipset         (clk_chipset),
		.reset               (reset),
		.sdram_ready_i       (sdram_ready_i),
		.ioctl_download_i    (ioctl_download_i),
		.ioctl_wr_i          (ioctl_wr_i),
		.ioctl_index_i       (ioctl_index_i),
		.ioctl_addr_i        (ioctl_addr_i),
		.ioctl_data_i        (ioctl_data_i),
		.processor_ready_i   (processor_ready_i),
		.address_direction_i (address_direction_i),
		.tandy_mode_i        (tandy_mode),
		.bios_request_o      (bios_request_o),
		.bios_protect_o      (bios_protect_o),
		.bios_address_o      (bios_address_o),
		.bios_data_o         (bios_data_o),
		.bios_write_n_o      (bios_write_n_o),
		.tandy_bios_flag_o   (tandy_bios_flag_o)
	);

	audio_dac u_audio_dac (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.opl_sample_i   (opl_sample_i),
		.speaker_i      (speaker_i),
		.tandy_sample_i (tandy_sample_i),
		.dac_sample_o   (dac_sample_o),
		.audio_o        (audio_o)
	);

endmodule

`default_nettype wire

/* tb_pcxt_glue.sv */
////////////////////////////////////////
// pcxt glue testbench
// table of download bytes and sound inputs against expected
// bus writes and dac words, plus reset, speed, strobe and density checks
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_pcxt_glue;

	import pcxt_pkg::*;

	localparam int CLK_PERIOD       = 8;
	localparam int RESET_CYCLES     = 16;
	localparam int NUM_ROWS         = 7;
	localparam int ROW_CYCLES       = 50;
	localparam int STROBE_WINDOW    = 256;
	localparam int CLK_CHECK_CYCLES = 16;
	localparam int SD_WINDOW        = 4096;
	// opl 16'h1000 with speaker term, mix 0x05000, accumulator step mix / 4
	localparam int SD_LEVEL         = 'h1400;
	localparam int SD_EXPECT        = SD_LEVEL * SD_WINDOW / 32768;
	localparam int TIMEOUT_CYCLES   = NUM_ROWS * 60 + SD_WINDOW + 2 * STROBE_WINDOW
		+ 3 * (CLK_CHECK_CYCLES + 4) + RESET_CYCLES + CPU_RESET_HOLD + 200;
	localparam logic [BUS_ADDR_W-1:0] ADDR_IDLE = '1;

	logic                        clk_chipset;
	logic                        reset;
	logic                        sdram_ready_i;
	logic                        ioctl_download_i;
	logic                        ioctl_wr_i;
	logic [BYTE_W-1:0]           ioctl_index_i;
	logic [IOCTL_ADDR_W-1:0]     ioctl_addr_i;
	logic [BYTE_W-1:0]           ioctl_data_i;
	logic                        processor_ready_i;
	logic                        address_direction_i;
	logic                        model_tandy_i;
	logic                        clk_4_77_i;
	logic                        clk_7_16_i;
	logic                        clk_14_318_i;
	logic [1:0]                  speed_sel_i;
	logic                        biu_done_i;
	logic                        opl2_clk_i;
	logic                        uart_clk_i;
	logic                        uart_slow_clk_i;
	logic [UART_SPEED_W-1:0]     uart_speed_i;
	logic [SAMPLE_W-1:0]         opl_sample_i;
	logic                        speaker_i;
	logic [TANDY_W-1:0]          tandy_sample_i;
	logic                        reset_cpu_o;
	logic                        bios_request_o;
	logic                        bios_protect_o;
	logic [BUS_ADDR_W-1:0]       bios_address_o;
	logic [BYTE_W-1:0]           bios_data_o;
	logic                        bios_write_n_o;
	logic                        tandy_bios_flag_o;
	logic                        clk_cpu_o;
	logic                        turbo_mode_o;
	logic                        opl2_en_o;
	logic                        uart_clk_en_o;
	logic [SAMPLE_W-1:0]         dac_sample_o;
	logic                        audio_o;

	// stimulus table, one entry per row
	string                       row_name     [NUM_ROWS];
	logic [BYTE_W-1:0]           row_index    [NUM_ROWS];
	logic [IOCTL_ADDR_W-1:0]     row_addr     [NUM_ROWS];
	logic [BYTE_W-1:0]           row_data     [NUM_ROWS];
	logic [BUS_ADDR_W-1:0]       row_exp_addr [NUM_ROWS];
	logic                        row_accept   [NUM_ROWS];
	logic [SAMPLE_W-1:0]         row_opl      [NUM_ROWS];
	logic                        row_spk      [NUM_ROWS];
	logic [TANDY_W-1:0]          row_tandy    [NUM_ROWS];
	logic [SAMPLE_W-1:0]         row_exp_dac  [NUM_ROWS];

	integer      seed = 32'h9767;
	logic [7:0]  slow_cnt;
	logic [23:0] cnt_hist;
	int          opl_edges;
	int          row;
	int          cyc;
	int          code;
	int          low_cnt;
	int          hold_cnt;
	int          strobe_cnt;
	int          edges_start;
	int          edges_seen;
	int          ones_cnt;

	pcxt_glue_top u_pcxt_glue_top (.*);

	initial begin
		clk_chipset = 1'b0;
		forever #(CLK_PERIOD / 2) clk_chipset = ~clk_chipset;
	end

	// slow clocks as one free running counter
	always @(negedge clk_chipset) begin
		slow_cnt        = slow_cnt + 1'b1;
		clk_14_318_i    = slow_cnt[0];
		clk_7_16_i      = slow_cnt[1];
		clk_4_77_i      = slow_cnt[2];
		uart_clk_i      = slow_cnt[2];
		opl2_clk_i      = slow_cnt[3];
		uart_slow_clk_i = slow_cnt[5];
		// opl2 rising edge
		if (slow_cnt[3:0] == 4'b1000) begin
			opl_edges++;
		end
	end

	// counter value at each rising edge, newest in the low byte
	always @(posedge clk_chipset) begin
		cnt_hist <= {cnt_hist[15:0], slow_cnt};
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_chipset);
		$display("Timeout, the run did not finish in the expected number of cycles");
		$display("Test failed");
		$fatal(1);
	end

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %0h actual %0h", test_name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// counts off by at most one are taken as exact
	function automatic int snap_if_close(input int expected, input int actual);
		if ((actual - expected) >= -1 && (actual - expected) <= 1) begin
			return expected;
		end
		return actual;
	endfunction

	// counter bit that carries the clock of each speed code
	function automatic logic speed_level(input int speed, input logic [7:0] cnt);
		case (speed)
			SPEED_14_318: return cnt[0];
			SPEED_7_16:   return cnt[1];
			default:      return cnt[2];
		endcase
	endfunction

	task automatic set_row(input int i, input string name, input logic [7:0] idx,
		input logic [24:0] addr, input logic [19:0] exp_addr, input logic accept,
		input logic [15:0] opl, input logic spk, input logic [7:0] tandy,
		input logic [15:0] exp_dac);
		row_name[i]     = name;
		row_index[i]    = idx;
		row_addr[i]     = addr;
		row_data[i]     = $random(seed);
		row_exp_addr[i] = exp_addr;
		row_accept[i]   = accept;
		row_opl[i]      = opl;
		row_spk[i]      = spk;
		row_tandy[i]    = tandy;
		row_exp_dac[i]  = exp_dac;
	endtask

	task automatic load_table();
		// row, name, index, download addr, bus addr, accepted, opl, speaker, tandy, dac word
		set_row(0, "pcxt_low", 8'd1, 25'h0001234, 20'hF1234, 1, 16'h0000, 1, 8'h00, 16'h0000);
		set_row(1, "tandy_top", 8'd2, 25'h000FFFF, 20'hFFFFF, 1, 16'h1000, 0, 8'h00, 16'h2800);
		set_row(2, "xtide_mid", 8'd3, 25'h0012ABC, 20'hEEABC, 1, 16'hFFFE, 1, 8'h01, 16'h00FF);
		set_row(3, "bad_index", 8'd5, 25'h0000010, 20'hFFFFF, 0, 16'h8000, 0, 8'h80, 16'h6000);
		set_row(4, "pcxt_64k", 8'd1, 25'h0010000, 20'hFFFFF, 0, 16'h7FFF, 1, 8'hFF, 16'h3EFF);
		set_row(5, "xtide_top", 8'd3, 25'h0007FFF, 20'hEFFFF, 1, 16'h0123, 0, 8'h10, 16'h3091);
		set_row(6, "tandy_16m", 8'd2, 25'h1000000, 20'hFFFFF, 0, 16'h0000, 0, 8'h00, 16'h2000);
	endtask

	initial begin
		// cpu off the bus, tandy model strapped during reset
		reset               = 1'b1;
		sdram_ready_i       = 1'b1;
		ioctl_download_i    = 1'b0;
		ioctl_wr_i          = 1'b0;
		ioctl_index_i       = '0;
		ioctl_addr_i        = '0;
		ioctl_data_i        = '0;
		processor_ready_i   = 1'b0;
		address_direction_i = 1'b1;
		model_tandy_i       = 1'b1;
		slow_cnt            = '0;
		opl_edges           = 0;
		clk_4_77_i          = 1'b0;
		clk_7_16_i          = 1'b0;
		clk_14_318_i        = 1'b0;
		opl2_clk_i          = 1'b0;
		uart_clk_i          = 1'b0;
		uart_slow_clk_i     = 1'b0;
		speed_sel_i         = SPEED_4_77;
		biu_done_i          = 1'b0;
		uart_speed_i        = '0;
		opl_sample_i        = '0;
		speaker_i           = 1'b1;
		tandy_sample_i      = '0;
		load_table();
		repeat (RESET_CYCLES) @(negedge clk_chipset);
		check_value("reset_write_n", 1, bios_write_n_o);
		check_value("reset_protect", 1, bios_protect_o);
		check_value("reset_address", ADDR_IDLE, bios_address_o);
		check_value("reset_turbo", 0, turbo_mode_o);
		check_value("cpu_reset_high", 1, reset_cpu_o);
		reset = 1'b0;

		////////////////////////////////////////
		// cpu reset stretch and model latch
		////////////////////////////////////////
		hold_cnt = 0;
		while (reset_cpu_o && hold_cnt < 2 * CPU_RESET_HOLD) begin
			@(negedge clk_chipset);
			hold_cnt++;
		end
		check_value("cpu_reset_hold", CPU_RESET_HOLD, hold_cnt);
		check_value("tandy_model_latch", 1, tandy_bios_flag_o);
		model_tandy_i = 1'b0;
		repeat (3) @(negedge clk_chipset);
		// model frozen once reset is gone
		check_value("tandy_model_frozen", 1, tandy_bios_flag_o);

		////////////////////////////////////////
		// bios download rows
		////////////////////////////////////////
		ioctl_download_i = 1'b1;
		repeat (2) @(negedge clk_chipset);
		check_value("download_protect", 0, bios_protect_o);
		check_value("download_request", 1, bios_request_o);
		for (row = 0; row < NUM_ROWS; row++) begin
			ioctl_wr_i     = 1'b1;
			ioctl_index_i  = row_index[row];
			ioctl_addr_i   = row_addr[row];
			ioctl_data_i   = row_data[row];
			opl_sample_i   = row_opl[row];
			speaker_i      = row_spk[row];
			tandy_sample_i = row_tandy[row];
			@(negedge clk_chipset);
			ioctl_wr_i = 1'b0;
			// mix is registered once
			check_value({row_name[row], "_dac"}, row_exp_dac[row], dac_sample_o);
			low_cnt = 0;
			for (cyc = 1; cyc < ROW_CYCLES; cyc++) begin
				@(negedge clk_chipset);
				if (!bios_write_n_o) begin
					low_cnt++;
					check_value({row_name[row], "_addr"}, row_exp_addr[row], bios_address_o);
					check_value({row_name[row], "_data"}, row_data[row], bios_data_o);
					check_value({row_name[row], "_tandy_flag"},
						row_index[row] == BIOS_IDX_TANDY, tandy_bios_flag_o);
				end
			end
			check_value({row_name[row], "_write_low"},
				row_accept[row] ? BIOS_WRITE_PULSE : 0, low_cnt);
			check_value({row_name[row], "_addr_idle"}, ADDR_IDLE, bios_address_o);
			check_value({row_name[row], "_protect"}, 0, bios_protect_o);
		end
		ioctl_download_i = 1'b0;
		repeat (2) @(negedge clk_chipset);
		check_value("end_protect", 1, bios_protect_o);
		check_value("end_request", 0, bios_request_o);

		////////////////////////////////////////
		// opl2 strobes and uart enable
		////////////////////////////////////////
		// slow clock levels are steady at the rising edge
		@(posedge clk_chipset);
		edges_start = opl_edges;
		check_value("uart_slow_level", uart_slow_clk_i, uart_clk_en_o);
		strobe_cnt = 0;
		repeat (STROBE_WINDOW) begin
			@(negedge clk_chipset);
			strobe_cnt += opl2_en_o;
		end
		@(posedge clk_chipset);
		edges_seen = opl_edges - edges_start;
		check_value("opl2_strobe_count", edges_seen, snap_if_close(edges_seen, strobe_cnt));

		// uart lane, enable is the strobe for any nonzero speed
		// uart clock is counter bit 2, one rising edge every 8 cycles
		@(negedge clk_chipset);
		uart_speed_i = 2'd1;
		strobe_cnt   = 0;
		repeat (STROBE_WINDOW) begin
			@(negedge clk_chipset);
			strobe_cnt += uart_clk_en_o;
		end
		check_value("uart_strobe_count", STROBE_WINDOW / 8,
			snap_if_close(STROBE_WINDOW / 8, strobe_cnt));

		////////////////////////////////////////
		// cpu speed latch
		////////////////////////////////////////
		for (code = 0; code < 3; code++) begin
			@(negedge clk_chipset);
			speed_sel_i = 2'(code);
			biu_done_i  = 1'b1;
			@(negedge clk_chipset);
			biu_done_i = 1'b0;
			check_value("turbo_speed_sel", code != SPEED_4_77, turbo_mode_o);
			// let the new selection reach the end of the three flops
			repeat (2) @(negedge clk_chipset);
			repeat (CLK_CHECK_CYCLES) begin
				@(negedge clk_chipset);
				check_value("cpu_clock_level", speed_level(code, cnt_hist[23:16]),
					clk_cpu_o);
			end
		end
		// no bus unit done, request must not land
		speed_sel_i = SPEED_4_77;
		repeat (2) @(negedge clk_chipset);
		check_value("turbo_held", 1, turbo_mode_o);

		////////////////////////////////////////
		// sigma-delta density
		////////////////////////////////////////
		opl_sample_i   = 16'h1000;
		speaker_i      = 1'b0;
		tandy_sample_i = '0;
		repeat (4) @(negedge clk_chipset);
		check_value("sd_dac_word", 16'h2800, dac_sample_o);
		ones_cnt = 0;
		repeat (SD_WINDOW) begin
			@(negedge clk_chipset);
			ones_cnt += audio_o;
		end
		check_value("sigma_delta_density", SD_EXPECT, snap_if_close(SD_EXPECT, ones_cnt));

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
pcxt_pkg.sv
clock_strobes.sv
cpu_clock_select.sv
cpu_reset_seq.sv
bios_loader.sv
audio_dac.sv
pcxt_glue_top.sv
tb_pcxt_glue.sv

/* Bender.yml */
package:
  name: pcxt_glue

sources:
  - pcxt_pkg.sv
  - clock_strobes.sv
  - cpu_clock_select.sv
  - cpu_reset_seq.sv
  - bios_loader.sv
  - audio_dac.sv
  - pcxt_glue_top.sv
  - target: simulation
    files:
      - tb_pcxt_glue.sv
